/* source/rans_pkg.sv */
`default_nettype none

package rans_pkg;

	// ========================================================================
	// coder constants
	// ========================================================================

	// probability scale, frequencies sum to PROB_SCALE
	localparam int SCALE_BITS = 8;
	localparam int PROB_SCALE = 1 << SCALE_BITS;

	// normalised state lives in [1 << RANS_L_SHIFT, 1 << STATE_BITS)
	localparam int RANS_L_SHIFT = 23;
	localparam int STATE_BITS = 32;

	// byte alphabet
	localparam int NUM_SYMBOLS = 256;

	// ========================================================================
	// vector types
	// ========================================================================

	typedef logic [STATE_BITS-1:0] state_t;

	// one extra bit so that a single symbol may own the whole scale
	typedef logic [SCALE_BITS:0] freq_t;

	typedef logic [7:0] sym_t;
	typedef logic [7:0] byte_t;

	// top level control phases
	typedef enum logic [1:0] {
		IDLE,
		BUILDTAB,
		ENCODE,
		FLUSH_WAIT
	} phase_t;

endpackage

`default_nettype wire

/* source/freq_table.sv */
`timescale 1ns/100ps
`default_nettype none

module freq_table import rans_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  tbl_valid,
	input  freq_t tbl_freq,
	input  sym_t  rd_sym,
	output freq_t rd_freq,
	output freq_t rd_start,
	output logic  table_done,
	output logic  table_ok
);

	// wide enough for 256 entries of the largest freq_t value
	localparam int SUM_BITS = $clog2(NUM_SYMBOLS) + $bits(freq_t);

	freq_t                freq_mem [NUM_SYMBOLS];
	freq_t                start_mem [NUM_SYMBOLS];
	sym_t                 load_cnt;
	logic [SUM_BITS-1:0]  sum_q;
	logic [SUM_BITS-1:0]  sum_next;
	logic                 last_entry;

	assign sum_next = sum_q + SUM_BITS'(tbl_freq);
	assign last_entry = (load_cnt == sym_t'(NUM_SYMBOLS - 1));

	// ========================================================================
	// load sequencing and sum check
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			load_cnt <= '0;
			sum_q <= '0;
			table_done <= 1'b0;
			table_ok <= 1'b0;
		end else begin
			table_done <= tbl_valid && last_entry;
			if (tbl_valid) begin
				load_cnt <= load_cnt + 1'b1;
				if (last_entry) begin
					// counter wraps, so the next load starts clean
					sum_q <= '0;
					table_ok <= (sum_next == SUM_BITS'(PROB_SCALE));
				end else begin
					sum_q <= sum_next;
				end
			end
		end
	end

	// ========================================================================
	// table storage
	// ========================================================================

	// start of a symbol is the sum of all earlier frequencies
	always_ff @(posedge clk) begin
		if (tbl_valid) begin
			freq_mem[load_cnt] <= tbl_freq;
			start_mem[load_cnt] <= freq_t'(sum_q);
		end
	end

	// registered read port, one cycle latency
	always_ff @(posedge clk) begin
		rd_freq <= freq_mem[rd_sym];
		rd_start <= start_mem[rd_sym];
	end

endmodule

`default_nettype wire

/* source/state_divider.sv */
`timescale 1ns/100ps
`default_nettype none

module state_divider import rans_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  logic   div_start,
	input  state_t dividend,
	input  freq_t  divisor,
	output state_t quotient,
	output freq_t  remainder,
	output logic   div_done
);

	localparam int CNT_BITS = $clog2(STATE_BITS);
	localparam int REM_BITS = $bits(freq_t) + 1;

	logic                busy;
	logic [CNT_BITS-1:0] bit_cnt;
	logic [REM_BITS-1:0] part_rem;
	logic [REM_BITS-1:0] shifted;
	logic                fits;
	freq_t               divisor_q;
	state_t              quo_q;

	// next dividend bit enters from the top of the quotient register
	assign shifted = {part_rem[REM_BITS-2:0], quo_q[STATE_BITS-1]};
	assign fits = (shifted >= {1'b0, divisor_q});

	// one bit per cycle, done after the last of STATE_BITS steps
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			bit_cnt <= '0;
			div_done <= 1'b0;
		end else begin
			div_done <= 1'b0;
			if (!busy) begin
				if (div_start) begin
					busy <= 1'b1;
					bit_cnt <= '0;
				end
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == CNT_BITS'(STATE_BITS - 1)) begin
					busy <= 1'b0;
					div_done <= 1'b1;
				end
			end
		end
	end

	// restoring step
	always_ff @(posedge clk) begin
		if (!busy && div_start) begin
			part_rem <= '0;
			quo_q <= dividend;
			divisor_q <= divisor;
		end else if (busy) begin
			if (fits) begin
				part_rem <= shifted - {1'b0, divisor_q};
			end else begin
				part_rem <= shifted;
			end
			quo_q <= {quo_q[STATE_BITS-2:0], fits};
		end
	end

	assign quotient = quo_q;
	assign remainder = part_rem[REM_BITS-2:0];

endmodule

`default_nettype wire

/* source/rans_step.sv */
`timescale 1ns/100ps
`default_nettype none

module rans_step import rans_pkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  sym_valid,
	input  logic  sym_last,
	input  sym_t  sym_data,
	output logic  sym_ready,
	output sym_t  rd_sym,
	input  freq_t rd_freq,
	input  freq_t rd_start,
	output logic  push,
	output logic  push_last,
	output byte_t push_byte,
	input  logic  room,
	output logic  step_done
);

	localparam state_t X_INIT = state_t'(1) << RANS_L_SHIFT;
	localparam int BOUND_SHIFT = RANS_L_SHIFT + 8 - SCALE_BITS;

	typedef enum logic [2:0] {
		READY,
		LOOKUP,
		RENORM,
		DIVIDE,
		FLUSH
	} step_state_t;

	step_state_t st;
	state_t      x_q;
	state_t      bound;
	state_t      x_div;
	state_t      quotient;
	freq_t       remainder;
	sym_t        sym_q;
	logic        last_q;
	logic [1:0]  flush_cnt;
	logic        need_renorm;
	logic        renorm_push;
	logic        flush_push;
	logic        div_start;
	logic        div_done;

	// ========================================================================
	// datapath
	// ========================================================================

	// state must stay below freq << BOUND_SHIFT before the division
	assign bound = state_t'(rd_freq) << BOUND_SHIFT;
	assign need_renorm = (x_q >= bound);

	// x' = (x / freq) << SCALE_BITS + x % freq + start
	assign x_div = (quotient << SCALE_BITS) + state_t'(remainder) + state_t'(rd_start);

	assign renorm_push = (st == RENORM) && need_renorm && room;
	assign flush_push = (st == FLUSH) && room;
	assign div_start = (st == RENORM) && !need_renorm;

	assign push = renorm_push || flush_push;
	assign push_byte = x_q[7:0];
	assign push_last = flush_push && (flush_cnt == 2'd3);
	assign step_done = push_last;

	assign sym_ready = (st == READY);
	assign rd_sym = sym_q;

	// ========================================================================
	// step FSM
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			st <= READY;
			x_q <= X_INIT;
			flush_cnt <= '0;
			last_q <= 1'b0;
		end else begin
			unique case (st)
				READY: begin
					if (sym_valid) begin
						last_q <= sym_last;
						st <= LOOKUP;
					end
				end
				// table read in flight
				LOOKUP: st <= RENORM;
				RENORM: begin
					if (renorm_push) begin
						x_q <= x_q >> 8;
					end else if (div_start) begin
						st <= DIVIDE;
					end
				end
				DIVIDE: begin
					if (div_done) begin
						x_q <= x_div;
						flush_cnt <= '0;
						st <= last_q ? FLUSH : READY;
					end
				end
				FLUSH: begin
					// low byte first
					if (flush_push) begin
						flush_cnt <= flush_cnt + 1'b1;
						x_q <= x_q >> 8;
						if (flush_cnt == 2'd3) begin
							x_q <= X_INIT;
							st <= READY;
						end
					end
				end
				default: st <= READY;
			endcase
		end
	end

	// symbol held for the table read and the whole step
	always_ff @(posedge clk) begin
		if (st == READY && sym_valid) begin
			sym_q <= sym_data;
		end
	end

	state_divider state_divider_i (
		.clk       (clk),
		.rst       (rst),
		.div_start (div_start),
		.dividend  (x_q),
		.divisor   (rd_freq),
		.quotient  (quotient),
		.remainder (remainder),
		.div_done  (div_done)
	);

endmodule

`default_nettype wire

/* source/byte_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_queue import rans_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  push,
	input  logic  push_last,
	input  byte_t push_byte,
	output logic  room,
	output logic  m_tvalid,
	output logic  m_tlast,
	input  logic  m_tready,
	output byte_t m_tdata
);

	localparam int PTR_BITS = $clog2(FIFO_DEPTH);

	byte_t               data_mem [FIFO_DEPTH];
	logic                last_mem [FIFO_DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   fill;
	logic                do_push;
	logic                do_pop;

	assign room = (fill != (PTR_BITS + 1)'(FIFO_DEPTH));
	assign m_tvalid = (fill != '0);
	assign do_push = push && room;
	assign do_pop = m_tvalid && m_tready;

	// head entry
	assign m_tdata = data_mem[rd_ptr];
	assign m_tlast = last_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (do_push && !do_pop) begin
				fill <= fill + 1'b1;
			end else if (do_pop && !do_push) begin
				fill <= fill - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			data_mem[wr_ptr] <= push_byte;
			last_mem[wr_ptr] <= push_last;
		end
	end

endmodule

`default_nettype wire

/* source/rans_encoder.sv */
`timescale 1ns/100ps
`default_nettype none

module rans_encoder import rans_pkg::*; #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  start,
	input  logic  tbl_valid,
	input  freq_t tbl_freq,
	input  logic  s_tvalid,
	output logic  s_tready,
	input  sym_t  s_tdata,
	input  logic  s_tlast,
	output logic  m_tvalid,
	input  logic  m_tready,
	output byte_t m_tdata,
	output logic  m_tlast,
	output logic  table_bad,
	output logic  done
);

	phase_t phase;
	logic   table_done;
	logic   table_ok;
	sym_t   rd_sym;
	freq_t  rd_freq;
	freq_t  rd_start;
	logic   sym_valid;
	logic   sym_ready;
	logic   push;
	logic   push_last;
	byte_t  push_byte;
	logic   room;
	logic   step_done;
	logic   out_last_xfer;

	// symbols only flow while encoding
	assign sym_valid = s_tvalid && (phase == ENCODE);
	assign s_tready = sym_ready && (phase == ENCODE);

	assign table_bad = (phase == BUILDTAB) && table_done && !table_ok;
	assign out_last_xfer = m_tvalid && m_tready && m_tlast;

	// ========================================================================
	// phase FSM
	// ========================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= IDLE;
			done <= 1'b0;
		end else begin
			done <= (phase == FLUSH_WAIT) && out_last_xfer;
			unique case (phase)
				IDLE: begin
					if (start) begin
						phase <= BUILDTAB;
					end
				end
				BUILDTAB: begin
					if (table_done) begin
						phase <= table_ok ? ENCODE : IDLE;
					end
				end
				// flush bytes are pushed by the time step_done rises
				ENCODE: begin
					if (step_done) begin
						phase <= FLUSH_WAIT;
					end
				end
				FLUSH_WAIT: begin
					if (out_last_xfer) begin
						phase <= IDLE;
					end
				end
				default: phase <= IDLE;
			endcase
		end
	end

	// ========================================================================
	// datapath
	// ========================================================================
	freq_table freq_table_i (
		.clk        (clk),
		.rst        (rst),
		.tbl_valid  (tbl_valid),
		.tbl_freq   (tbl_freq),
		.rd_sym     (rd_sym),
		.rd_freq    (rd_freq),
		.rd_start   (rd_start),
		.table_done (table_done),
		.table_ok   (table_ok)
	);

	rans_step rans_step_i (
		.clk       (clk),
		.rst       (rst),
		.sym_valid (sym_valid),
		.sym_last  (s_tlast),
		.sym_data  (s_tdata),
		.sym_ready (sym_ready),
		.rd_sym    (rd_sym),
		.rd_freq   (rd_freq),
		.rd_start  (rd_start),
		.push      (push),
		.push_last (push_last),
		.push_byte (push_byte),
		.room      (room),
		.step_done (step_done)
	);

	byte_queue #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) byte_queue_i (
		.clk       (clk),
		.rst       (rst),
		.push      (push),
		.push_last (push_last),
		.push_byte (push_byte),
		.room      (room),
		.m_tvalid  (m_tvalid),
		.m_tlast   (m_tlast),
		.m_tready  (m_tready),
		.m_tdata   (m_tdata)
	);

endmodule

`default_nettype wire

/* sim/rans_encoder_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module rans_encoder_asserts import rans_pkg::*; (
	input logic   clk,
	input logic   rst,
	input phase_t phase,
	input logic   s_tvalid,
	input logic   s_tready,
	input logic   s_tlast,
	input logic   m_tvalid,
	input logic   m_tready,
	input byte_t  m_tdata,
	input logic   m_tlast,
	input logic   done
);

	// running count of failed properties
	int fail_count = 0;

	// set by the last accepted symbol, cleared once the run is back to idle
	logic last_taken;

	always_ff @(posedge clk) begin
		if (rst || phase == IDLE) begin
			last_taken <= 1'b0;
		end else if (s_tvalid && s_tready && s_tlast) begin
			last_taken <= 1'b1;
		end
	end

	// head entry held while the sink stalls
	property out_stable;
		@(posedge clk) disable iff (rst)
		m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast);
	endproperty

	// no symbol taken between the last one and the end of the run
	property ready_low_after_last;
		@(posedge clk) disable iff (rst)
		last_taken |-> !s_tready;
	endproperty

	// done is registered, so it comes exactly one cycle after the last byte
	property done_after_last;
		@(posedge clk) disable iff (rst)
		done == $past(m_tvalid && m_tready && m_tlast);
	endproperty

	out_stable_a: assert property (out_stable) else begin
		fail_count++;
		$error("m_tvalid, m_tdata or m_tlast changed while m_tready was low");
	end

	ready_low_after_last_a: assert property (ready_low_after_last) else begin
		fail_count++;
		$error("s_tready high after the last symbol before the run ended");
	end

	done_after_last_a: assert property (done_after_last) else begin
		fail_count++;
		$error("done did not pulse exactly one cycle after the m_tlast transfer");
	end

endmodule

bind rans_encoder rans_encoder_asserts rans_encoder_asserts_i (
	.clk      (clk),
	.rst      (rst),
	.phase    (phase),
	.s_tvalid (s_tvalid),
	.s_tready (s_tready),
	.s_tlast  (s_tlast),
	.m_tvalid (m_tvalid),
	.m_tready (m_tready),
	.m_tdata  (m_tdata),
	.m_tlast  (m_tlast),
	.done     (done)
);

`default_nettype wire

/* sim/rans_encoder_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module rans_encoder_tb import rans_pkg::*; ();

	localparam int WAIT_LIMIT = 2000;
	localparam int MAX_MSG = 64;

	logic  clk;
	logic  rst;
	logic  start;
	logic  tbl_valid;
	freq_t tbl_freq;
	logic  s_tvalid;
	logic  s_tready;
	sym_t  s_tdata;
	logic  s_tlast;
	logic  m_tvalid;
	logic  m_tready;
	byte_t m_tdata;
	logic  m_tlast;
	logic  table_bad;
	logic  done;

	// model tables and message
	int freq_tab [NUM_SYMBOLS];
	int start_tab [NUM_SYMBOLS];
	int live_syms [$];
	int msg [MAX_MSG];
	int msg_len;

	// expected output, last flag above the byte
	logic [8:0] exp_q [$];

	bit random_ready = 1'b0;
	int errors = 0;
	int timeouts = 0;
	int bytes_checked = 0;

	initial clk = 1'b0;
	always #20 clk = ~clk;

	rans_encoder #(
		.FIFO_DEPTH (16)
	) rans_encoder_i (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.tbl_valid (tbl_valid),
		.tbl_freq  (tbl_freq),
		.s_tvalid  (s_tvalid),
		.s_tready  (s_tready),
		.s_tdata   (s_tdata),
		.s_tlast   (s_tlast),
		.m_tvalid  (m_tvalid),
		.m_tready  (m_tready),
		.m_tdata   (m_tdata),
		.m_tlast   (m_tlast),
		.table_bad (table_bad),
		.done      (done)
	);

	// ========================================================================
	// reporting
	// ========================================================================
	task automatic value_error(input string name, input logic [8:0] got, input logic [8:0] exp);
		errors++;
		$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
	endtask

	task automatic finish_run();
		int assert_fails;
		assert_fails = rans_encoder_i.rans_encoder_asserts_i.fail_count;
		$display("bytes checked %0d, errors %0d, assertion failures %0d, timeouts %0d",
			bytes_checked, errors, assert_fails, timeouts);
		if (errors == 0 && assert_fails == 0 && timeouts == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	endtask

	task automatic check_idle_outputs();
		assert (m_tvalid === 1'b0) else value_error("m_tvalid", 9'(m_tvalid), 9'd0);
		assert (s_tready === 1'b0) else value_error("s_tready", 9'(s_tready), 9'd0);
		assert (done === 1'b0) else value_error("done", 9'(done), 9'd0);
		assert (table_bad === 1'b0) else value_error("table_bad", 9'(table_bad), 9'd0);
	endtask

	// ========================================================================
	// software rANS model
	// ========================================================================

	// random table summing to PROB_SCALE, weighted towards the low symbols
	task automatic build_table();
		int i;
		int idx;
		int acc;
		for (i = 0; i < NUM_SYMBOLS; i++) begin
			freq_tab[i] = 0;
		end
		for (i = 0; i < PROB_SCALE; i++) begin
			if (i < 160) begin
				idx = $urandom_range(0, 15);
			end else begin
				idx = $urandom_range(0, NUM_SYMBOLS - 1);
			end
			freq_tab[idx]++;
		end
		acc = 0;
		live_syms.delete();
		for (i = 0; i < NUM_SYMBOLS; i++) begin
			start_tab[i] = acc;
			acc += freq_tab[i];
			if (freq_tab[i] != 0) begin
				live_syms.push_back(i);
			end
		end
	endtask

	task automatic make_message(input int len);
		int i;
		msg_len = len;
		for (i = 0; i < len; i++) begin
			msg[i] = live_syms[$urandom_range(0, live_syms.size() - 1)];
		end
	endtask

	task automatic encode_model();
		int i;
		int k;
		logic [63:0] x;
		logic [63:0] f;
		logic [63:0] c;
		x = 64'd1 << RANS_L_SHIFT;
		for (i = 0; i < msg_len; i++) begin
			f = 64'(freq_tab[msg[i]]);
			c = 64'(start_tab[msg[i]]);
			// renormalise until the state is below the symbol bound
			while (x >= (f << (RANS_L_SHIFT + 8 - SCALE_BITS))) begin
				exp_q.push_back({1'b0, x[7:0]});
				x = x >> 8;
			end
			x = ((x / f) << SCALE_BITS) + (x % f) + c;
		end
		for (k = 0; k < 4; k++) begin
			exp_q.push_back({(k == 3), x[7:0]});
			x = x >> 8;
		end
	endtask

	// ========================================================================
	// stimulus
	// ========================================================================
	task automatic load_table(input int extra);
		int i;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		for (i = 0; i < NUM_SYMBOLS; i++) begin
			tbl_valid = 1'b1;
			tbl_freq = freq_t'(freq_tab[i] + ((i == 0) ? extra : 0));
			@(negedge clk);
		end
		tbl_valid = 1'b0;
	endtask

	task automatic wait_table_result(output bit bad);
		int cnt;
		cnt = 0;
		while (!table_bad && !s_tready) begin
			@(negedge clk);
			cnt++;
			if (cnt > WAIT_LIMIT) begin
				timeouts++;
				$display("Timeout: table load gave neither table_bad nor s_tready");
				finish_run();
			end
		end
		bad = table_bad;
	endtask

	task automatic send_message();
		int i;
		int cnt;
		for (i = 0; i < msg_len; i++) begin
			s_tvalid = 1'b1;
			s_tdata = sym_t'(msg[i]);
			s_tlast = (i == msg_len - 1);
			cnt = 0;
			while (!s_tready) begin
				@(negedge clk);
				cnt++;
				if (cnt > WAIT_LIMIT) begin
					timeouts++;
					$display("Timeout: s_tready never rose for symbol %0d", i);
					finish_run();
				end
			end
			// ready seen here, so the transfer is on the next rising edge
			@(negedge clk);
		end
		s_tvalid = 1'b0;
		s_tlast = 1'b0;
	endtask

	task automatic wait_done();
		int cnt;
		cnt = 0;
		while (!done) begin
			@(negedge clk);
			cnt++;
			if (cnt > WAIT_LIMIT) begin
				timeouts++;
				$display("Timeout: done never pulsed after the last symbol");
				finish_run();
			end
		end
		assert (exp_q.size() == 0) else begin
			errors++;
			$display("%0d expected bytes never came out before done", exp_q.size());
			exp_q.delete();
		end
	endtask

	task automatic run_message(input bit rand_ready);
		bit bad;
		random_ready = rand_ready;
		encode_model();
		load_table(0);
		wait_table_result(bad);
		assert (!bad) else begin
			errors++;
			$display("a table summing to %0d was refused", PROB_SCALE);
		end
		send_message();
		wait_done();
	endtask

	// ========================================================================
	// output sink and byte check
	// ========================================================================
	task automatic check_byte();
		logic [8:0] exp;
		if (exp_q.size() == 0) begin
			errors++;
			$display("unexpected output byte %h at %0t with nothing expected", m_tdata, $time);
		end else begin
			exp = exp_q.pop_front();
			assert (m_tdata === exp[7:0]) else value_error("m_tdata", 9'(m_tdata), 9'(exp[7:0]));
			assert (m_tlast === exp[8]) else value_error("m_tlast", 9'(m_tlast), 9'(exp[8]));
			bytes_checked++;
		end
	endtask

	// outputs only change on the rising edge, so they are settled here
	initial begin
		m_tready = 1'b0;
		forever begin
			@(negedge clk);
			if (rst) begin
				m_tready = 1'b0;
			end else begin
				m_tready = random_ready ? ($urandom_range(0, 1) == 1) : 1'b1;
				if (m_tvalid && m_tready) begin
					check_byte();
				end
			end
		end
	end

	// ========================================================================
	// main sequence
	// ========================================================================
	initial begin
		bit bad;
		int i;
		$timeformat(-9, 1, " ns", 12);
		void'($urandom(32'ha291_0366));
		rst = 1'b1;
		start = 1'b0;
		tbl_valid = 1'b0;
		tbl_freq = '0;
		s_tvalid = 1'b0;
		s_tdata = '0;
		s_tlast = 1'b0;
		for (i = 0; i < 16; i++) begin
			@(negedge clk);
			check_idle_outputs();
		end
		rst = 1'b0;
		for (i = 0; i < 4; i++) begin
			@(negedge clk);
			check_idle_outputs();
		end

		// sum of 257 must be refused, with nothing following
		build_table();
		load_table(1);
		wait_table_result(bad);
		assert (bad) else begin
			errors++;
			$display("a table with a wrong sum was accepted");
		end
		for (i = 0; i < 20; i++) begin
			@(negedge clk);
			check_idle_outputs();
		end

		// long message, then again under random back-pressure
		make_message(40);
		run_message(1'b0);
		run_message(1'b1);

		// single symbol twice, each from the initial state
		make_message(1);
		run_message(1'b0);
		run_message(1'b0);

		finish_run();
	end

endmodule

`default_nettype wire

/* rans_encoder.f */
source/rans_pkg.sv
source/freq_table.sv
source/state_divider.sv
source/rans_step.sv
source/byte_queue.sv
source/rans_encoder.sv
sim/rans_encoder_asserts.sv
sim/rans_encoder_tb.sv

/* Bender.yml */
package:
  name: rans_encoder

sources:
  - source/rans_pkg.sv
  - source/freq_table.sv
  - source/state_divider.sv
  - source/rans_step.sv
  - source/byte_queue.sv
  - source/rans_encoder.sv
  - target: simulation
    files:
      - sim/rans_encoder_asserts.sv
      - sim/rans_encoder_tb.sv
